/* chunk/stacker.sv */
`timescale 1ns/1ps
`default_nettype none
module stacker import frame_pkg::*, stream_pkg::*; (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  pix_beat_t   in_beat_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output chunk_beat_t out_beat_o
);

  chunk_t     chunk_q;  // shift register, oldest pixel ends up in slot 0
  logic       last_q;
  logic [2:0] slot_q;
  logic       full_q;   // chunk waiting downstream
  logic       in_fire;
  logic       out_fire;

  // a new pixel may enter on the cycle the waiting chunk leaves
  assign in_ready_o = !full_q || out_ready_i;
  assign in_fire    = in_valid_i && in_ready_o;
  assign out_fire   = full_q && out_ready_i;

  assign out_valid_o     = full_q;
  assign out_beat_o.data = chunk_q;
  assign out_beat_o.last = last_q;

  always_ff @(posedge clk_camera) begin
    if (in_fire) begin
      chunk_q <= {in_beat_i.pix, chunk_q[px_per_chunk_c-1:1]};
      last_q  <= in_beat_i.last;  // pixel 7's flag is the one kept
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot_q <= '0;
      full_q <= 1'b0;
    end else begin
      if (in_fire) slot_q <= slot_q + 3'd1;  // 7 -> 0
      if (in_fire && slot_q == 3'd7) begin
        full_q <= 1'b1;
      end else if (out_fire) begin
        full_q <= 1'b0;
      end
    end
  end

  // frame size must be a multiple of the chunk size
  a_last_in_slot7: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    in_fire && in_beat_i.last |-> slot_q == 3'd7);

endmodule
`default_nettype wire

/* chunk/unstacker.sv */
`timescale 1ns/1ps
`default_nettype none
module unstacker import frame_pkg::*, stream_pkg::*; (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  chunk_beat_t in_beat_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output pix_beat_t   out_beat_o
);

  localparam int SW = $clog2(px_per_chunk_c);
  localparam logic [SW-1:0] LAST_SLOT = SW'(px_per_chunk_c - 1);

  chunk_t        chunk_q;
  logic          last_q;   // flag of the held chunk
  logic [SW-1:0] slot_q;   // pixel now presented
  logic          full_q;
  logic          in_fire;
  logic          out_fire;
  logic          final_px;

  assign final_px = (slot_q == LAST_SLOT);
  assign out_fire = full_q && out_ready_i;
  // refill as the eighth pixel goes out
  assign in_ready_o = !full_q || (out_ready_i && final_px);
  assign in_fire    = in_valid_i && in_ready_o;

  assign out_valid_o     = full_q;
  assign out_beat_o.pix  = chunk_q[slot_q];
  assign out_beat_o.last = last_q && final_px;

  always_ff @(posedge clk_camera) begin
    if (in_fire) begin
      chunk_q <= in_beat_i.data;
      last_q  <= in_beat_i.last;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot_q <= '0;
      full_q <= 1'b0;
    end else if (in_fire) begin
      slot_q <= '0;  // load wins over the final pop
      full_q <= 1'b1;
    end else if (out_fire) begin
      slot_q <= slot_q + 1'b1;
      if (final_px) full_q <= 1'b0;  // drained
    end
  end

endmodule
`default_nettype wire

/* chunk_path_top.f */
common/frame_pkg.sv
common/stream_pkg.sv
rtl/pattern_gen.sv
rtl/stream_fifo.sv
chunk/stacker.sv
chunk/unstacker.sv
rtl/scan_out.sv
rtl/chunk_path_top.sv
sim/clk_gen.sv
sim/chunk_path_tb.sv

/* common/frame_pkg.sv */
package frame_pkg;

  // default geometry, top level passes its own copy down
  localparam int frame_w_c      = 32;
  localparam int frame_h_c      = 4;
  localparam int px_per_chunk_c = 8;  // 8 x 16b = one 128b chunk

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } pix565_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix888_t;

  // shown whenever the scan has nothing to draw
  localparam pix565_t fill_color_c = pix565_t'(16'h2277);

  typedef enum logic [1:0] {
    pat_index,     // running pixel index
    pat_gradient,  // r from x, g from y
    pat_white,
    pat_checker
  } pattern_sel_t;

  typedef struct packed {
    pix565_t pix;
    logic    last;  // final pixel of a frame
  } pix_beat_t;

  // zero-pad each channel up to 8 bits
  function automatic pix888_t to_888(input pix565_t p);
    to_888 = '{r: {p.r, 3'b000}, g: {p.g, 2'b00}, b: {p.b, 3'b000}};
  endfunction

endpackage

/* common/stream_pkg.sv */
package stream_pkg;
  import frame_pkg::*;

  // pixel 0 sits in bits 15:0
  typedef pix565_t [px_per_chunk_c-1:0] chunk_t;

  typedef struct packed {
    chunk_t data;
    logic   last;  // chunk holds the frame's last pixel
  } chunk_beat_t;

endpackage

/* rtl/chunk_path_top.sv */
`timescale 1ns/1ps
`default_nettype none
module chunk_path_top import frame_pkg::*, stream_pkg::*; #(
  parameter int FRAME_W = frame_w_c,  // 32
  parameter int FRAME_H = frame_h_c   // 4
) (
  input  logic         clk_camera,
  input  logic         recent_reset,
  input  pattern_sel_t pattern_sel_i,
  input  logic         draw_i,
  output pix888_t      pix_o,
  output logic         pix_valid_o,
  output logic         frame_end_o
);

  logic        gen_valid, gen_ready;    // pattern -> stacker
  pix_beat_t   gen_beat;
  logic        stk_valid, stk_ready;    // stacker -> chunk fifo
  chunk_beat_t stk_beat;
  logic        cf_valid, cf_ready;      // chunk fifo -> unstacker
  chunk_beat_t cf_beat;
  logic        ust_valid, ust_ready;    // unstacker -> pixel fifo
  pix_beat_t   ust_beat;
  logic        pf_valid, pf_ready;      // pixel fifo -> scan
  pix_beat_t   pf_beat;

  pattern_gen #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) pattern_gen0 (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .out_valid_o   (gen_valid),
    .out_ready_i   (gen_ready),
    .out_beat_o    (gen_beat)
  );

  stacker stacker0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .in_valid_i   (gen_valid),
    .in_ready_o   (gen_ready),
    .in_beat_i    (gen_beat),
    .out_valid_o  (stk_valid),
    .out_ready_i  (stk_ready),
    .out_beat_o   (stk_beat)
  );

  // stands in for the memory round trip
  stream_fifo #(.payload_t(chunk_beat_t), .FIFO_DEPTH(4)) chunk_fifo0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .in_valid_i   (stk_valid),
    .in_ready_o   (stk_ready),
    .in_beat_i    (stk_beat),
    .out_valid_o  (cf_valid),
    .out_ready_i  (cf_ready),
    .out_beat_o   (cf_beat)
  );

  unstacker unstacker0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .in_valid_i   (cf_valid),
    .in_ready_o   (cf_ready),
    .in_beat_i    (cf_beat),
    .out_valid_o  (ust_valid),
    .out_ready_i  (ust_ready),
    .out_beat_o   (ust_beat)
  );

  stream_fifo #(.payload_t(pix_beat_t), .FIFO_DEPTH(8)) pix_fifo0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .in_valid_i   (ust_valid),
    .in_ready_o   (ust_ready),
    .in_beat_i    (ust_beat),
    .out_valid_o  (pf_valid),
    .out_ready_i  (pf_ready),
    .out_beat_o   (pf_beat)
  );

  scan_out #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) scan_out0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .draw_i       (draw_i),
    .in_valid_i   (pf_valid),
    .in_ready_o   (pf_ready),
    .in_beat_i    (pf_beat),
    .pix_o        (pix_o),
    .pix_valid_o  (pix_valid_o),
    .frame_end_o  (frame_end_o)
  );

endmodule
`default_nettype wire

/* rtl/pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none
module pattern_gen import frame_pkg::*; #(
  parameter int FRAME_W = frame_w_c,
  parameter int FRAME_H = frame_h_c
) (
  input  logic         clk_camera,
  input  logic         recent_reset,
  input  pattern_sel_t pattern_sel_i,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output pix_beat_t    out_beat_o
);

  localparam int XW = $clog2(FRAME_W);
  localparam int YW = $clog2(FRAME_H);

  logic [XW-1:0] x_q;
  logic [YW-1:0] y_q;
  logic [15:0]   idx_q;     // index within frame, wraps at 16b
  pattern_sel_t  sel_q;     // held for the whole frame
  logic          armed_q;   // low for one cycle after reset while sel is sampled
  logic          fire;
  logic          at_end;
  pix565_t       pix;

  assign fire   = out_valid_o && out_ready_i;
  assign at_end = (x_q == XW'(FRAME_W - 1)) && (y_q == YW'(FRAME_H - 1));

  always_comb begin
    pix = '0;
    case (sel_q)
      pat_index:    pix = pix565_t'(idx_q);
      pat_gradient: begin
        pix.r = 5'(x_q);  // x mod 32
        pix.g = 6'(y_q);  // y mod 64
      end
      pat_white:    pix = pix565_t'(16'hffff);
      default:      pix = pix565_t'({16{x_q[0] ^ y_q[0]}});
    endcase
  end

  assign out_valid_o     = armed_q;
  assign out_beat_o.pix  = pix;
  assign out_beat_o.last = at_end;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      x_q     <= '0;
      y_q     <= '0;
      idx_q   <= '0;
      sel_q   <= pat_index;
      armed_q <= 1'b0;
    end else if (!armed_q) begin
      sel_q   <= pattern_sel_i;  // first frame after reset
      armed_q <= 1'b1;
    end else if (fire) begin
      if (at_end) begin
        x_q   <= '0;
        y_q   <= '0;
        idx_q <= '0;
        sel_q <= pattern_sel_i;  // new frame, new pattern
      end else begin
        idx_q <= idx_q + 16'd1;
        if (x_q == XW'(FRAME_W - 1)) begin
          x_q <= '0;
          y_q <= y_q + 1'b1;
        end else begin
          x_q <= x_q + 1'b1;
        end
      end
    end
  end

  a_x_in_range: assert property (
    @(posedge clk_camera) disable iff (recent_reset) int'(x_q) < FRAME_W);

endmodule
`default_nettype wire

/* rtl/scan_out.sv */
`timescale 1ns/1ps
`default_nettype none
module scan_out import frame_pkg::*; #(
  parameter int FRAME_W = frame_w_c,
  parameter int FRAME_H = frame_h_c
) (
  input  logic      clk_camera,
  input  logic      recent_reset,
  input  logic      draw_i,       // one raster position per strobe
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  pix_beat_t in_beat_i,
  output pix888_t   pix_o,
  output logic      pix_valid_o,
  output logic      frame_end_o
);

  localparam int XW = $clog2(FRAME_W);
  localparam int YW = $clog2(FRAME_H);

  logic [XW-1:0] x_q;
  logic [YW-1:0] y_q;
  logic          last_col;
  logic          at_end;
  logic          accept;

  assign last_col = (x_q == XW'(FRAME_W - 1));
  assign at_end   = last_col && (y_q == YW'(FRAME_H - 1));

  // last pixel waits for the raster's final position
  assign in_ready_o = draw_i && (!in_beat_i.last || at_end);
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      x_q <= '0;
      y_q <= '0;
    end else if (draw_i) begin
      if (last_col) begin
        x_q <= '0;
        y_q <= at_end ? '0 : y_q + 1'b1;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (draw_i) pix_o <= to_888(accept ? in_beat_i.pix : fill_color_c);
  end

  // one-cycle pulses on draw cycles only
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pix_valid_o <= draw_i && accept;
      frame_end_o <= draw_i && accept && in_beat_i.last;
    end
  end

  // a refused pixel waits unchanged at the fifo head
  a_hold_pixel: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_beat_i));

endmodule
`default_nettype wire

/* rtl/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
module stream_fifo import frame_pkg::*; #(
  parameter type payload_t  = pix_beat_t,
  parameter int  FIFO_DEPTH = 4  // power of two
) (
  input  logic     clk_camera,
  input  logic     recent_reset,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_beat_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_beat_o
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  payload_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  assign in_ready_o  = (count_q != CW'(FIFO_DEPTH));  // full blocks input
  assign out_valid_o = (count_q != '0);
  assign out_beat_o  = mem[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_camera) begin
    if (push) mem[wr_ptr_q] <= in_beat_i;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps since depth is 2^n
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  // a beat refused while full stays on offer until it goes in
  a_no_push_full: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_beat_i));

  // count tracks the pointers over time
  a_no_pop_empty: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    count_q <= CW'(FIFO_DEPTH) && AW'(wr_ptr_q - rd_ptr_q) == AW'(count_q));

endmodule
`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build chunk_path_tb with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_chunk_path

verilator --binary --timing --assert -Wno-fatal --top-module chunk_path_tb \
  -f chunk_path_top.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

/* sim/chunk_path_tb.sv */
`timescale 1ns/1ps
module chunk_path_tb import frame_pkg::*; ();

  localparam int FRAME_W       = frame_w_c;
  localparam int FRAME_H       = frame_h_c;
  localparam int N_PIX         = FRAME_W * FRAME_H;  // pixels per frame
  localparam int CLK_PERIOD_NS = 20;
  localparam int NUM_ROWS      = 6;

  typedef struct packed {
    pattern_sel_t sel;
    logic [3:0]   frames;  // frames to check
    logic         gated;   // draw from lfsr or on every cycle
  } test_row_t;

  localparam test_row_t rows_c [NUM_ROWS] = '{
    '{sel: pat_index,    frames: 4'd2, gated: 1'b0},
    '{sel: pat_gradient, frames: 4'd2, gated: 1'b0},
    '{sel: pat_white,    frames: 4'd2, gated: 1'b1},
    '{sel: pat_checker,  frames: 4'd3, gated: 1'b1},
    '{sel: pat_index,    frames: 4'd2, gated: 1'b1},
    '{sel: pat_gradient, frames: 4'd2, gated: 1'b1}
  };

  logic         clk_camera, recent_reset, restart;
  pattern_sel_t pattern_sel;
  logic         draw;
  pix888_t      pix;
  logic         pix_valid, frame_end;

  pattern_sel_t cur_sel;      // pattern of the running row
  int unsigned  got;          // valid pixels seen since reset
  logic         rst_seen;     // reset high at the previous negedge
  logic         draw_seen;    // draw value the last posedge sampled
  logic [31:0]  lfsr_q;

  clk_gen clk_gen0 (.restart_i(restart), .clk_camera(clk_camera), .recent_reset(recent_reset));

  chunk_path_top #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) dut0 (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel),
    .draw_i        (draw),
    .pix_o         (pix),
    .pix_valid_o   (pix_valid),
    .frame_end_o   (frame_end)
  );

  // galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // pixel n of the stream, straight from the pattern rules
  function automatic pix565_t ref_pixel(input pattern_sel_t sel, input int unsigned n);
    int unsigned pos, x, y;
    logic [15:0] raw;
    pos = n % N_PIX;
    x   = pos % FRAME_W;
    y   = pos / FRAME_W;
    case (sel)
      pat_index:    raw = pos[15:0];
      pat_gradient: raw = {5'(x % 32), 6'(y % 64), 5'd0};
      pat_white:    raw = 16'hffff;
      default:      raw = (((x ^ y) & 1) != 0) ? 16'hffff : 16'h0000;
    endcase
    return pix565_t'(raw);
  endfunction

  function automatic pix888_t expand_rgb(input pix565_t p);
    pix888_t w;
    w.r = 8'(p.r) << 3;  // low bits zero
    w.g = 8'(p.g) << 2;
    w.b = 8'(p.b) << 3;
    return w;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_pix(input string name, input pix888_t exp, input pix888_t act);
    if (act !== exp)
      stop_with_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_with_error($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
  endtask

  // outputs settle after the posedge, so look at them on the falling edge
  always @(negedge clk_camera) begin
    if (recent_reset || rst_seen) begin
      if (recent_reset) got = 0;
      check_flag("pix_valid_o", 1'b0, pix_valid);
      check_flag("frame_end_o", 1'b0, frame_end);
    end else if (draw_seen && pix_valid) begin
      check_pix("pix_o", expand_rgb(ref_pixel(cur_sel, got)), pix);
      check_flag("frame_end_o", logic'((got % N_PIX) == N_PIX - 1), frame_end);
      got++;
    end else if (draw_seen) begin
      check_pix("pix_o", expand_rgb(fill_color_c), pix);  // nothing handed over
      check_flag("frame_end_o", 1'b0, frame_end);
    end else begin
      check_flag("pix_valid_o", 1'b0, pix_valid);  // no draw, no pulse
      check_flag("frame_end_o", 1'b0, frame_end);
    end
    rst_seen  = recent_reset;
    draw_seen = draw;
  end

  task automatic run_row(input test_row_t row);
    int unsigned target;
    target = int'(row.frames) * N_PIX;
    @(posedge clk_camera);
    cur_sel = row.sel;
    pattern_sel <= row.sel;
    draw        <= 1'b0;
    restart     <= 1'b1;
    @(posedge clk_camera);
    restart <= 1'b0;
    @(negedge clk_camera);
    while (recent_reset) @(negedge clk_camera);
    @(posedge clk_camera);
    while (got < target) begin
      if (row.gated) begin
        lfsr_q = lfsr_step(lfsr_q);  // one step per bit
        draw <= lfsr_q[0];
      end else begin
        draw <= 1'b1;
      end
      @(posedge clk_camera);
    end
    draw <= 1'b0;
  endtask

  initial begin : watchdog
    longint unsigned limit;
    limit = 0;
    for (int i = 0; i < NUM_ROWS; i++)
      limit += longint'(rows_c[i].frames) * N_PIX * 4 + 400;  // 400 for reset and fill
    #(limit * CLK_PERIOD_NS);
    stop_with_error($sformatf("watchdog expired after %0d cycles, pixels still missing", limit));
  end

  initial begin : main_seq
    pattern_sel <= pat_index;
    draw        <= 1'b0;
    restart     <= 1'b0;
    cur_sel      = pat_index;
    got          = 0;
    rst_seen     = 1'b1;
    draw_seen    = 1'b0;
    lfsr_q       = 32'd99956;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows_c[i]);
    end
    repeat (3) @(posedge clk_camera);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps
module clk_gen #(
  parameter int HALF_PERIOD_NS = 10,  // 20 ns period
  parameter int RESET_CYCLES   = 8
) (
  input  logic restart_i,     // request another reset pulse
  output logic clk_camera,
  output logic recent_reset
);

  int unsigned hold_q = RESET_CYCLES;  // reset cycles still to go

  initial clk_camera = 1'b0;
  always #(HALF_PERIOD_NS) clk_camera = ~clk_camera;

  always @(posedge clk_camera) begin
    if (restart_i) hold_q <= RESET_CYCLES;
    else if (hold_q != 0) hold_q <= hold_q - 1;
  end

  assign recent_reset = (hold_q != 0);  // high from time 0

endmodule
